// File: verilog/scope_pkg.sv
//------------------------------
// shared widths, types and constants of the capture control core
// frames carry four samples of 12 bits plus their clock strobes
//------------------------------

package scope_pkg;

	//------------------------------
	// constants
	//------------------------------
	localparam int CMD_BYTES       = 8;            // bytes per host command
	localparam int NUM_SAMPLES     = 4;            // samples per frame
	localparam int FIFO_DEPTH      = 16;           // frames held by the FIFO
	localparam int WORDS_PER_FRAME = 4;            // output words per frame

	localparam logic [31:0] FW_VERSION   = 32'd11;
	localparam logic [31:0] FRAME_MARKER = 32'hdeadbeef;

	localparam logic [7:0] TRIG_IMMEDIATE = 8'd0;
	localparam logic [7:0] TRIG_THRESHOLD = 8'd1;

	localparam int LOWER_THRESH = -10;             // sample 0 must dip below this
	localparam int UPPER_THRESH = 10;              // then rise above this

	//------------------------------
	// plain vectors
	//------------------------------
	typedef logic        [7:0]  byte_t;
	typedef logic        [31:0] word_t;
	typedef logic signed [11:0] sample_t;
	typedef logic        [1:0]  strobe_t;
	typedef logic        [31:0] len_t;         // readout byte count
	typedef logic        [15:0] take_t;        // frames to capture

	// sample 3 sits in the upper bits of each array
	typedef struct packed {
		strobe_t [NUM_SAMPLES-1:0] strobe;
		sample_t [NUM_SAMPLES-1:0] sample;
	} frame_t;

	typedef enum logic {
		REPLY_WORD,
		REPLY_FRAMES
	} reply_kind_t;

	typedef struct packed {
		reply_kind_t kind;
		len_t        len;                          // bytes to send
		word_t       word;                         // payload of a word reply
	} reply_req_t;

	typedef struct packed {
		byte_t trig_type;
		take_t take;
	} arm_req_t;

	typedef enum logic [7:0] {
		CMD_READ     = 8'd0,
		CMD_VERSION  = 8'd2,
		CMD_SPI_MODE = 8'd4,
		CMD_ARM      = 8'd5
	} cmd_t;

endpackage

// File: verilog/command_decoder.sv
//------------------------------
// collects 8-byte host commands and dispatches them
// unknown codes and arms while capture is busy are dropped silently
//------------------------------
`timescale 1ns/1ns

module command_decoder (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_cmd_valid,
	input  scope_pkg::byte_t      i_cmd_data,
	output logic                  o_cmd_ready,
	output logic                  o_reply_start,
	output scope_pkg::reply_req_t o_reply_req,
	input  logic                  i_reply_done,
	output logic                  o_arm,
	output scope_pkg::arm_req_t   o_arm_req,
	input  logic                  i_capture_idle,
	output logic [1:0]            o_spi_mode
);
	import scope_pkg::*;

	typedef enum logic [1:0] {
		ST_RX,
		ST_PROC,
		ST_WAIT
	} state_t;

	state_t                         state;
	byte_t                          rx_data [CMD_BYTES];
	logic [$clog2(CMD_BYTES)-1:0]   rx_cnt;
	cmd_t                           cmd;

	assign cmd         = cmd_t'(rx_data[0]);
	assign o_cmd_ready = (state == ST_RX);

	//------------------------------
	// control
	//------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= ST_RX;
			rx_cnt        <= '0;
			o_spi_mode    <= '0;
			o_reply_start <= 1'b0;
			o_arm         <= 1'b0;
		end else begin
			o_reply_start <= 1'b0;
			o_arm         <= 1'b0;
			case (state)
			ST_RX: if (i_cmd_valid) begin
				if (rx_cnt == ($clog2(CMD_BYTES))'(CMD_BYTES - 1)) begin
					rx_cnt <= '0;
					state  <= ST_PROC;             // last byte in
				end else begin
					rx_cnt <= rx_cnt + 1'b1;
				end
			end
			ST_PROC: begin
				state <= ST_RX;                    // arm and unknown codes
				case (cmd)
				CMD_READ, CMD_VERSION: begin
					o_reply_start <= 1'b1;
					state         <= ST_WAIT;
				end
				CMD_SPI_MODE: begin
					o_spi_mode    <= rx_data[1][1:0];
					o_reply_start <= 1'b1;
					state         <= ST_WAIT;
				end
				CMD_ARM: o_arm <= i_capture_idle; // busy capture drops the arm
				default: ;
				endcase
			end
			ST_WAIT: if (i_reply_done) state <= ST_RX;
			default: state <= ST_RX;
			endcase
		end
	end

	//------------------------------
	// command bytes and request payloads
	//------------------------------
	always_ff @(posedge clk) begin
		if (o_cmd_ready && i_cmd_valid)
			rx_data[rx_cnt] <= i_cmd_data;
		if (state == ST_PROC) begin
			case (cmd)
			CMD_READ: o_reply_req <= '{kind: REPLY_FRAMES,
				len: {rx_data[7], rx_data[6], rx_data[5], rx_data[4]}, word: '0};
			CMD_VERSION: o_reply_req <= '{kind: REPLY_WORD, len: len_t'(4), word: FW_VERSION};
			CMD_SPI_MODE: o_reply_req <= '{kind: REPLY_WORD, len: len_t'(4),
				word: word_t'(rx_data[1])};        // echo the mode byte
			CMD_ARM: o_arm_req <= '{trig_type: rx_data[1],
				take: {rx_data[5], rx_data[4]}};
			default: ;
			endcase
		end
	end

	// only one reply may be outstanding at a time
	a_single_reply: assert property (@(posedge clk) disable iff (!rstn)
		i_reply_done |-> (state == ST_WAIT && !o_reply_start))
		else $error("reply_done without a pending reply");

endmodule

// File: verilog/sample_capture.sv
//------------------------------
// trigger FSM and frame writer, never stalls
// capture ends after take frames or when the FIFO fills, later frames are lost
//------------------------------
`timescale 1ns/1ns

module sample_capture (
	input  logic                clk,
	input  logic                rstn,
	input  scope_pkg::frame_t   i_frame,
	input  logic                i_arm,
	input  scope_pkg::arm_req_t i_arm_req,
	output logic                o_idle,
	output logic                o_wr,
	output scope_pkg::frame_t   o_wr_frame,
	input  logic                i_full
);
	import scope_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_LOW,
		ST_WAIT_HIGH,
		ST_CAPTURE
	} state_t;

	state_t  state;
	frame_t  frame_q;
	sample_t in_s0;
	take_t   take_q;
	take_t   wr_cnt;
	logic    last_wr;

	// trigger looks at the live input, so frame_q holds the trigger frame
	// on the first capture cycle
	assign in_s0 = i_frame.sample[0];

	assign last_wr    = (wr_cnt + take_t'(1) >= take_q);
	assign o_idle     = (state == ST_IDLE);
	assign o_wr       = (state == ST_CAPTURE) && !i_full && (wr_cnt != take_q);
	assign o_wr_frame = frame_q;

	always_ff @(posedge clk) begin
		frame_q <= i_frame;                        // one stage of input register
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state  <= ST_IDLE;
			take_q <= '0;
			wr_cnt <= '0;
		end else begin
			case (state)
			ST_IDLE: if (i_arm) begin
				take_q <= i_arm_req.take;
				wr_cnt <= '0;
				case (i_arm_req.trig_type)
				TRIG_IMMEDIATE: state <= ST_CAPTURE;
				TRIG_THRESHOLD: state <= ST_WAIT_LOW;
				default: ;                         // unknown trigger, stay idle
				endcase
			end
			ST_WAIT_LOW:  if (in_s0 < LOWER_THRESH) state <= ST_WAIT_HIGH;
			ST_WAIT_HIGH: if (in_s0 > UPPER_THRESH) state <= ST_CAPTURE;
			ST_CAPTURE: begin
				if (o_wr)
					wr_cnt <= wr_cnt + 1'b1;
				if (i_full || last_wr)
					state <= ST_IDLE;              // done or out of room
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// one write per clock until take is reached or the FIFO fills
	a_no_gap: assert property (@(posedge clk) disable iff (!rstn)
		(o_wr && !last_wr) |=> (o_wr || i_full))
		else $error("capture skipped a frame before take or full");

endmodule

// File: verilog/frame_fifo.sv
//------------------------------
// synchronous frame FIFO, FIFO_DEPTH entries
// read data is registered, valid one cycle after i_rd
//------------------------------
`timescale 1ns/1ns

module frame_fifo (
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_wr,
	input  scope_pkg::frame_t i_wr_frame,
	output logic              o_full,
	input  logic              i_rd,
	output scope_pkg::frame_t o_rd_frame,
	output logic              o_empty
);
	import scope_pkg::*;

	frame_t                          mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]     count;
	logic                            wr_ok;
	logic                            rd_ok;

	assign o_full  = (count == FIFO_DEPTH);
	assign o_empty = (count == 0);
	assign wr_ok   = i_wr && !o_full;
	assign rd_ok   = i_rd && !o_empty;

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wr_frame;
		if (rd_ok)
			o_rd_frame <= mem[rd_ptr];             // held until the next read
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;           // wraps at depth
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: ;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
		o_full |-> !i_wr)
		else $error("write into a full FIFO");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
		o_empty |-> !i_rd)
		else $error("read from an empty FIFO");

endmodule

// File: verilog/readout_engine.sv
//------------------------------
// reply stream serializer, four words per captured frame
// keep and last follow the remaining byte count, a frame reply waits on an empty FIFO
//------------------------------
`timescale 1ns/1ns

module readout_engine (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_reply_start,
	input  scope_pkg::reply_req_t i_reply_req,
	output logic                  o_reply_done,
	output logic                  o_rd,
	input  scope_pkg::frame_t     i_rd_frame,
	input  logic                  i_empty,
	output logic                  o_tvalid,
	output scope_pkg::word_t      o_tdata,
	output logic [3:0]            o_tkeep,
	output logic                  o_tlast,
	input  logic                  i_tready
);
	import scope_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_LOAD,
		ST_SEND
	} state_t;

	state_t                              state;
	len_t                                rem;
	logic [$clog2(WORDS_PER_FRAME)-1:0]  widx;

	// word n of a frame, see the frame word order
	function automatic word_t frame_word(input frame_t f,
			input logic [$clog2(WORDS_PER_FRAME)-1:0] idx);
		word_t w;
		case (idx)
		2'd0:    w = {4'd0, f.sample[1], 4'd0, f.sample[0]};
		2'd1:    w = {4'd0, f.sample[3], 4'd0, f.sample[2]};
		2'd2:    w = {24'd0, f.strobe};            // strobe 3 highest
		default: w = FRAME_MARKER;
		endcase
		return w;
	endfunction

	assign o_rd    = (state == ST_FETCH) && !i_empty;
	assign o_tlast = (rem <= 4);
	assign o_tkeep = (rem >= 4) ? 4'b1111 :
	                 (rem == 3) ? 4'b0111 :
	                 (rem == 2) ? 4'b0011 :
	                 (rem == 1) ? 4'b0001 : 4'b0000;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state        <= ST_IDLE;
			rem          <= '0;
			widx         <= '0;
			o_tvalid     <= 1'b0;
			o_reply_done <= 1'b0;
		end else begin
			o_reply_done <= 1'b0;
			case (state)
			ST_IDLE: if (i_reply_start) begin
				rem  <= i_reply_req.len;
				widx <= '0;
				if (i_reply_req.kind == REPLY_WORD) begin
					o_tvalid <= 1'b1;
					state    <= ST_SEND;
				end else begin
					state <= ST_FETCH;
				end
			end
			ST_FETCH: if (!i_empty) state <= ST_LOAD; // read issued this cycle
			ST_LOAD: begin
				o_tvalid <= 1'b1;                  // FIFO output now valid
				state    <= ST_SEND;
			end
			ST_SEND: if (i_tready) begin
				rem <= (rem > 4) ? rem - len_t'(4) : '0;
				if (o_tlast) begin
					o_tvalid     <= 1'b0;
					o_reply_done <= 1'b1;
					state        <= ST_IDLE;
				end else if (widx == WORDS_PER_FRAME - 1) begin
					o_tvalid <= 1'b0;
					widx     <= '0;
					state    <= ST_FETCH;          // next frame
				end else begin
					widx <= widx + 1'b1;
				end
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// payload register, loaded whenever a new word goes on the bus
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_reply_start)
			o_tdata <= i_reply_req.word;
		else if (state == ST_LOAD)
			o_tdata <= frame_word(i_rd_frame, '0);
		else if (state == ST_SEND && i_tready && widx != WORDS_PER_FRAME - 1)
			o_tdata <= frame_word(i_rd_frame, widx + 1'b1);
	end

	a_hold_stalled: assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata)))
		else $error("output word changed while stalled");

endmodule

// File: verilog/scope_ctrl.sv
//------------------------------
// capture control core, single clock domain
// frames arrive already assembled on i_frame, one per clock
//------------------------------
`timescale 1ns/1ns

module scope_ctrl (
	input  logic              clk,
	input  logic              rstn,
	// host command bytes
	input  logic              i_cmd_valid,
	input  scope_pkg::byte_t  i_cmd_data,
	output logic              o_cmd_ready,
	// assembled ADC frame
	input  scope_pkg::frame_t i_frame,
	// reply stream
	output logic              o_tvalid,
	output scope_pkg::word_t  o_tdata,
	output logic [3:0]        o_tkeep,
	output logic              o_tlast,
	input  logic              i_tready,
	output logic [1:0]        o_spi_mode
);
	import scope_pkg::*;

	reply_req_t reply_req;
	arm_req_t   arm_req;
	frame_t     wr_frame;
	frame_t     rd_frame;
	logic       reply_start;
	logic       reply_done;
	logic       arm;
	logic       capture_idle;
	logic       fifo_wr;
	logic       fifo_rd;
	logic       fifo_full;
	logic       fifo_empty;

	command_decoder u_decoder (
		.clk(clk), .rstn(rstn),
		.i_cmd_valid(i_cmd_valid), .i_cmd_data(i_cmd_data), .o_cmd_ready(o_cmd_ready),
		.o_reply_start(reply_start), .o_reply_req(reply_req), .i_reply_done(reply_done),
		.o_arm(arm), .o_arm_req(arm_req), .i_capture_idle(capture_idle),
		.o_spi_mode(o_spi_mode)
	);

	sample_capture u_capture (
		.clk(clk), .rstn(rstn), .i_frame(i_frame),
		.i_arm(arm), .i_arm_req(arm_req), .o_idle(capture_idle),
		.o_wr(fifo_wr), .o_wr_frame(wr_frame), .i_full(fifo_full)
	);

	frame_fifo u_fifo (
		.clk(clk), .rstn(rstn),
		.i_wr(fifo_wr), .i_wr_frame(wr_frame), .o_full(fifo_full),
		.i_rd(fifo_rd), .o_rd_frame(rd_frame), .o_empty(fifo_empty)
	);

	readout_engine u_readout (
		.clk(clk), .rstn(rstn),
		.i_reply_start(reply_start), .i_reply_req(reply_req), .o_reply_done(reply_done),
		.o_rd(fifo_rd), .i_rd_frame(rd_frame), .i_empty(fifo_empty),
		.o_tvalid(o_tvalid), .o_tdata(o_tdata), .o_tkeep(o_tkeep), .o_tlast(o_tlast),
		.i_tready(i_tready)
	);

endmodule

// File: testbench/tb_scope_ctrl.sv
//------------------------------
// self-checking testbench for scope_ctrl, steps come from testbench/scope_tests.txt
// run from the project root, frame numbers must stay below 2048
//------------------------------
`timescale 1ns/1ns

module tb_scope_ctrl;
	import scope_pkg::*;

	logic       clk;
	logic       rstn;
	logic       i_cmd_valid;
	byte_t      i_cmd_data;
	logic       o_cmd_ready;
	frame_t     i_frame;
	logic       o_tvalid;
	word_t      o_tdata;
	logic [3:0] o_tkeep;
	logic       o_tlast;
	logic       i_tready;
	logic [1:0] o_spi_mode;

	frame_t       history [2048];                  // indexed by frame number
	logic [135:0] steps [32];
	logic [31:0]  lfsr = 32'hcf1cb482;
	int           frame_no = 0;                    // frame now on i_frame
	int           dip_at = 1 << 30;
	int           rise_at = 1 << 30;
	int           accept_frame = 0;
	int           arm_frame = 0;
	logic         stall_en = 1'b0;

	scope_ctrl dut0 (
		.clk(clk), .rstn(rstn),
		.i_cmd_valid(i_cmd_valid), .i_cmd_data(i_cmd_data), .o_cmd_ready(o_cmd_ready),
		.i_frame(i_frame),
		.o_tvalid(o_tvalid), .o_tdata(o_tdata), .o_tkeep(o_tkeep), .o_tlast(o_tlast),
		.i_tready(i_tready), .o_spi_mode(o_spi_mode)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//------------------------------
	// random bits and frame source
	//------------------------------
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};                // one step per bit
			lfsr = galois_step(lfsr);
		end
		return v;
	endfunction

	task automatic drive_frame();
		frame_t f;
		if (frame_no >= rise_at)
			f.sample[0] = sample_t'(20);
		else if (frame_no >= dip_at)
			f.sample[0] = sample_t'(-20);
		else
			f.sample[0] = '0;
		f.sample[1] = sample_t'(frame_no % 2048);  // frame number tag
		f.sample[2] = sample_t'(rand_bits(12));
		f.sample[3] = sample_t'(rand_bits(12));
		f.strobe    = 8'(rand_bits(8));
		history[frame_no % 2048] = f;
		i_frame = f;
	endtask

	initial begin
		logic [31:0] rb;
		i_tready = 1'b1;
		drive_frame();
		forever begin
			@(posedge clk);
			#2;
			frame_no = frame_no + 1;
			drive_frame();
			if (stall_en) begin
				rb = rand_bits(1);
				i_tready = rb[0];                  // host drops ready at random
			end else begin
				i_tready = 1'b1;
			end
		end
	end

	//------------------------------
	// checks and failure handling
	//------------------------------
	task automatic end_in_failure();
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			end_in_failure();
		end
	endtask

	// word k of a frame: samples 1|0, samples 3|2, strobes, marker
	function automatic word_t expected_word(input frame_t h, input int k);
		case (k)
		0:       return {4'b0, h.sample[1], 4'b0, h.sample[0]};
		1:       return {4'b0, h.sample[3], 4'b0, h.sample[2]};
		2:       return {24'b0, h.strobe};
		default: return FRAME_MARKER;
		endcase
	endfunction

	function automatic logic [3:0] keep_for(input int r);
		if (r >= 4)
			return 4'b1111;
		return 4'((1 << r) - 1);
	endfunction

	//------------------------------
	// host side
	//------------------------------
	task automatic send_byte(input byte_t b);
		int   waited;
		logic taken;
		waited = 0;
		taken  = 1'b0;
		i_cmd_valid = 1'b1;
		i_cmd_data  = b;
		while (!taken) begin
			@(negedge clk);
			taken = o_cmd_ready;
			if (taken)
				accept_frame = frame_no;
			@(posedge clk);
			#2;
			waited++;
			if (!taken && waited > 300) begin
				$display("timeout: command byte %0d was never accepted", b);
				end_in_failure();
			end
		end
	endtask

	// byte 0 goes first
	task automatic send_cmd(input logic [63:0] cmd);
		@(posedge clk);
		#2;
		for (int i = 0; i < CMD_BYTES; i++)
			send_byte(cmd[8*i +: 8]);
		i_cmd_valid = 1'b0;
	endtask

	task automatic read_word(output word_t w, output logic [3:0] k, output logic l);
		int   waited;
		logic got;
		waited = 0;
		got    = 1'b0;
		while (!got) begin
			@(negedge clk);                        // moves on the next rising edge
			if (o_tvalid && i_tready) begin
				got = 1'b1;
				w   = o_tdata;
				k   = o_tkeep;
				l   = o_tlast;
			end
			waited++;
			if (!got && waited > 2000) begin
				$display("timeout: no reply word arrived");
				end_in_failure();
			end
		end
	endtask

	task automatic word_step(input logic [63:0] cmd, input word_t exp);
		word_t      w;
		logic [3:0] k;
		logic       l;
		send_cmd(cmd);
		check(32'(o_cmd_ready), 0, "ready low while the command runs");
		read_word(w, k, l);
		check(w, exp, "reply word");
		check(32'(k), 32'hf, "reply keep");
		check(32'(l), 32'h1, "reply last");
	endtask

	task automatic arm_step(input int trig, input int take, input int dip, input int rise);
		int start;
		int waited;
		@(negedge clk);
		if (trig == int'(TRIG_THRESHOLD)) begin
			dip_at  = frame_no + dip;              // profile starts after the arm lands
			rise_at = frame_no + rise;
		end
		send_cmd({16'h0, 16'(take), 16'h0, 8'(trig), CMD_ARM});
		arm_frame = accept_frame;
		start  = (trig == int'(TRIG_THRESHOLD)) ? rise_at : arm_frame;
		waited = 0;
		// one frame per clock, so the capture is over after this many frames
		while (frame_no < start + ((take < FIFO_DEPTH) ? take : FIFO_DEPTH) + 8) begin
			@(negedge clk);
			check(32'(o_tvalid), 0, "no reply to an arm command");
			waited++;
			if (waited > 500) begin
				$display("timeout: capture window never passed");
				end_in_failure();
			end
		end
	endtask

	task automatic read_step(input int len, input int stall, input int rule, input int last_keep);
		int         rem;
		int         widx;
		int         id;
		logic       first;
		logic       below;
		word_t      w;
		logic [3:0] k;
		logic       l;
		@(negedge clk);
		stall_en = (stall != 0);
		send_cmd({32'(len), 24'h0, CMD_READ});
		rem   = len;
		widx  = 0;
		id    = 0;
		first = 1'b1;
		while (rem > 0) begin
			read_word(w, k, l);
			check(32'(k), 32'(keep_for(rem)), "keep from remaining count");
			check(32'(l), 32'(rem <= 4), "last from remaining count");
			if (widx == 0)
				id = first ? int'(w[27:16]) : id + 1;  // consecutive frames
			if (frame_no >= 2048) begin
				$display("frame counter ran past the history size");
				end_in_failure();
			end
			check(w, expected_word(history[id], widx), "frame word");
			if (first) begin
				first = 1'b0;
				if (rule == 0) begin
					check(32'(id >= arm_frame && id <= arm_frame + 4), 1, "first frame after arm");
				end else begin
					check(id, rise_at, "first frame at the trigger rise");
					check(32'(history[id].sample[0] > UPPER_THRESH), 1, "trigger frame level");
					below = 1'b0;
					for (int j = arm_frame; j < id; j++)
						if (history[j].sample[0] < LOWER_THRESH)
							below = 1'b1;
					check(32'(below), 1, "dip below lower threshold before trigger");
				end
			end
			widx = (widx + 1) % WORDS_PER_FRAME;
			rem  = (rem > 4) ? rem - 4 : 0;
		end
		check(32'(k), last_keep, "keep of the final word");
		stall_en = 1'b0;
	endtask

	//------------------------------
	// main sequence
	//------------------------------
	initial begin
		logic [135:0] st;
		int           s;
		rstn        = 1'b0;
		i_cmd_valid = 1'b0;
		i_cmd_data  = '0;
		for (int i = 0; i < 32; i++)
			steps[i] = '0;
		$readmemh("testbench/scope_tests.txt", steps);
		if (steps[0][135:128] == 8'h00) begin
			$display("no test steps were read from the data file");
			end_in_failure();
		end
		repeat (16) @(posedge clk);
		#2;
		rstn = 1'b1;
		check(32'(o_cmd_ready), 1, "ready after reset");
		check(32'(o_tvalid), 0, "valid after reset");
		check(32'(o_spi_mode), 0, "mode level after reset");
		s = 0;
		while (s < 32 && steps[s][135:128] != 8'h00) begin
			st = steps[s];
			case (st[135:128])
			8'h01: word_step({56'h0, CMD_VERSION}, st[127:96]);
			8'h02: begin
				word_step({48'h0, st[103:96], CMD_SPI_MODE}, st[95:64]);
				check(32'(o_spi_mode), st[63:32], "mode level");
			end
			8'h03: arm_step(int'(st[127:96]), int'(st[95:64]), int'(st[63:32]), int'(st[31:0]));
			8'h04: read_step(int'(st[127:96]), int'(st[95:64]), int'(st[63:32]), int'(st[31:0]));
			default: begin
				$display("unknown step kind %0h in the data file", st[135:128]);
				end_in_failure();
			end
			endcase
			s++;
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: testbench/scope_tests.txt
// one step per line, fields in hex: kind_a_b_c_d
// 01 version a=word | 02 mode a=byte b=echo c=level | 03 arm a=trigger b=take c=dip d=rise
// 04 read a=bytes b=stall c=first frame rule (0 after arm, 1 trigger rise) d=final keep
01_0000000b_00000000_00000000_00000000
02_00000007_00000007_00000003_00000000
02_00000002_00000002_00000002_00000000
// immediate capture, whole frames, no stalls
03_00000000_00000004_00000000_00000000
04_00000040_00000000_00000000_0000000f
// threshold trigger, dip after 16 frames, rise after 24
03_00000001_00000006_00000010_00000018
04_00000060_00000001_00000001_0000000f
// odd byte counts under stalls
03_00000000_00000003_00000000_00000000
04_0000002e_00000001_00000000_00000003
03_00000000_00000001_00000000_00000000
04_00000009_00000001_00000000_00000001
// take beyond the FIFO depth, then a fresh capture must start empty
03_00000000_00000028_00000000_00000000
04_00000100_00000001_00000000_0000000f
03_00000000_00000002_00000000_00000000
04_0000001e_00000000_00000000_00000003
01_0000000b_00000000_00000000_00000000

// File: scope_ctrl.f
verilog/scope_pkg.sv
verilog/command_decoder.sv
verilog/sample_capture.sv
verilog/frame_fifo.sv
verilog/readout_engine.sv
verilog/scope_ctrl.sv
testbench/tb_scope_ctrl.sv

// File: Makefile
# Verilator flow for the capture control core, run from the project root

VERILATOR  ?= verilator
TB_TOP     ?= tb_scope_ctrl
RTL_TOP    ?= scope_ctrl
FILELIST   ?= scope_ctrl.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Everything OK
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= verilog/scope_pkg.sv verilog/command_decoder.sv verilog/sample_capture.sv \
              verilog/frame_fifo.sv verilog/readout_engine.sv verilog/scope_ctrl.sv
TB_SRCS    ?= testbench/tb_scope_ctrl.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
